//--- rtl/ibuf_pkg.sv
package ibuf_pkg;

    // window geometry
    localparam int BYTE_W     = 8;
    localparam int LANES      = 6;
    localparam int HALF       = 3;
    localparam int BANKS      = 3;
    localparam int WORD_W     = 32;
    localparam int WORD_BYTES = 4;

    // layer codes seen on cfg_layer_typ
    localparam logic [3:0] LAYER_CONV = 4'd0;
    localparam logic [3:0] LAYER_POOL = 4'd2;

    // write strobe codes
    // shift codes drop the lowest k bytes and place the rest from lane 0
    localparam logic [2:0] STRB_SHIFT0 = 3'd0;
    localparam logic [2:0] STRB_SHIFT1 = 3'd1;
    localparam logic [2:0] STRB_SHIFT2 = 3'd2;
    localparam logic [2:0] STRB_SHIFT3 = 3'd3;
    // whole word placed from lane 2 or lane 1
    localparam logic [2:0] STRB_AT2    = 3'd5;
    localparam logic [2:0] STRB_AT1    = 3'd6;

    typedef logic [BYTE_W-1:0] lane_t;

    // lane 0 is the front of the window
    typedef lane_t [LANES-1:0] window_t;

    typedef enum logic [2:0] {
        OP_HOLD,
        OP_LOAD,
        OP_STEP,
        OP_HALF,
        OP_CLEAR,
        OP_TAKE_UPPER
    } bank_op_t;

endpackage

//--- rtl/ibuf_word_align.sv
module ibuf_word_align (
    input  logic [ibuf_pkg::WORD_W-1:0] di,
    input  logic                        di_revert,
    input  logic [2:0]                  conv_wstrb,
    input  ibuf_pkg::lane_t             init,
    output ibuf_pkg::window_t           lane_data,
    output logic [ibuf_pkg::LANES-1:0]  lane_wr,
    output logic [ibuf_pkg::LANES-1:0]  lane_valid
);

    ibuf_pkg::lane_t word_byte [ibuf_pkg::WORD_BYTES];
    logic [1:0]      shift;
    logic [2:0]      start;

    // byte 0 of the word comes from the top byte when reversed
    always_comb begin
        for (int b = 0; b < ibuf_pkg::WORD_BYTES; b++) begin
            if (di_revert) begin
                word_byte[b] = di[ibuf_pkg::BYTE_W*(ibuf_pkg::WORD_BYTES-1-b) +: ibuf_pkg::BYTE_W];
            end else begin
                word_byte[b] = di[ibuf_pkg::BYTE_W*b +: ibuf_pkg::BYTE_W];
            end
        end
    end

    assign shift = conv_wstrb[1:0];
    assign start = (conv_wstrb == ibuf_pkg::STRB_AT2) ? 3'd2 : 3'd1;

    always_comb begin
        for (int i = 0; i < ibuf_pkg::LANES; i++) begin
            lane_data[i] = init;
        end
        lane_wr    = '0;
        lane_valid = '0;

        case (conv_wstrb)
            ibuf_pkg::STRB_SHIFT0, ibuf_pkg::STRB_SHIFT1,
            ibuf_pkg::STRB_SHIFT2, ibuf_pkg::STRB_SHIFT3: begin
                // the whole window is rewritten, the tail with init
                lane_wr = '1;
                for (int i = 0; i < ibuf_pkg::WORD_BYTES; i++) begin
                    if (i + int'(shift) < ibuf_pkg::WORD_BYTES) begin
                        lane_data[i]  = word_byte[i + int'(shift)];
                        lane_valid[i] = 1'b1;
                    end
                end
            end
            ibuf_pkg::STRB_AT2, ibuf_pkg::STRB_AT1: begin
                for (int i = 0; i < ibuf_pkg::WORD_BYTES; i++) begin
                    lane_data[i + int'(start)]  = word_byte[i];
                    lane_wr[i + int'(start)]    = 1'b1;
                    lane_valid[i + int'(start)] = 1'b1;
                end
            end
            // codes 4 and 7 write nothing
            default: ;
        endcase
    end

endmodule

//--- rtl/ibuf_move_ctrl.sv
module ibuf_move_ctrl (
    input  logic               enb,
    input  logic               ld_wrn,
    input  logic [3:0]         cfg_layer_typ,
    input  logic [1:0]         bank_sel,
    input  logic               conv_se_load,
    input  logic               conv_fi_load,
    output ibuf_pkg::bank_op_t bank_op [ibuf_pkg::BANKS]
);

    logic is_conv;
    logic is_pool;

    assign is_conv = (cfg_layer_typ == ibuf_pkg::LAYER_CONV);
    assign is_pool = (cfg_layer_typ == ibuf_pkg::LAYER_POOL);

    always_comb begin
        for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
            bank_op[b] = ibuf_pkg::OP_HOLD;
        end

        if (enb) begin
            if (ld_wrn) begin
                // bank_sel 1..3 picks bank 0..2, 0 picks none
                if (is_conv || is_pool) begin
                    for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
                        if (int'(bank_sel) == b + 1) begin
                            bank_op[b] = ibuf_pkg::OP_LOAD;
                        end
                    end
                end
            end else if (is_pool) begin
                for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
                    bank_op[b] = ibuf_pkg::OP_STEP;
                end
            end else if (is_conv) begin
                case ({conv_se_load, conv_fi_load})
                    2'b11: begin
                        bank_op[0] = ibuf_pkg::OP_CLEAR;
                        bank_op[1] = ibuf_pkg::OP_HALF;
                        bank_op[2] = ibuf_pkg::OP_HALF;
                    end
                    2'b10: begin
                        // bank 1 picks up the upper half of bank 2
                        bank_op[0] = ibuf_pkg::OP_CLEAR;
                        bank_op[1] = ibuf_pkg::OP_TAKE_UPPER;
                        bank_op[2] = ibuf_pkg::OP_CLEAR;
                    end
                    2'b01: begin
                        bank_op[0] = ibuf_pkg::OP_CLEAR;
                        bank_op[1] = ibuf_pkg::OP_CLEAR;
                        bank_op[2] = ibuf_pkg::OP_HALF;
                    end
                    default: begin
                        for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
                            bank_op[b] = ibuf_pkg::OP_STEP;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/ibuf_bank_array.sv
module ibuf_bank_array (
    input  logic                       clk,
    input  logic                       resetn,
    input  ibuf_pkg::bank_op_t         bank_op [ibuf_pkg::BANKS],
    input  ibuf_pkg::window_t          lane_data,
    input  logic [ibuf_pkg::LANES-1:0] lane_wr,
    input  logic [ibuf_pkg::LANES-1:0] lane_valid,
    input  ibuf_pkg::lane_t            init,
    output ibuf_pkg::window_t          bank_data [ibuf_pkg::BANKS],
    output logic [ibuf_pkg::LANES-1:0] bank_valid [ibuf_pkg::BANKS]
);

    ibuf_pkg::window_t          data_q  [ibuf_pkg::BANKS];
    ibuf_pkg::window_t          data_d  [ibuf_pkg::BANKS];
    logic [ibuf_pkg::LANES-1:0] valid_q [ibuf_pkg::BANKS];
    logic [ibuf_pkg::LANES-1:0] valid_d [ibuf_pkg::BANKS];

    always_comb begin
        for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
            data_d[b]  = data_q[b];
            valid_d[b] = valid_q[b];

            case (bank_op[b])
                ibuf_pkg::OP_LOAD: begin
                    for (int l = 0; l < ibuf_pkg::LANES; l++) begin
                        if (lane_wr[l]) begin
                            data_d[b][l]  = lane_data[l];
                            valid_d[b][l] = lane_valid[l];
                        end
                    end
                end

                ibuf_pkg::OP_STEP: begin
                    for (int l = 0; l < ibuf_pkg::LANES - 1; l++) begin
                        data_d[b][l]  = data_q[b][l+1];
                        valid_d[b][l] = valid_q[b][l+1];
                    end
                    data_d[b][ibuf_pkg::LANES-1]  = init;
                    valid_d[b][ibuf_pkg::LANES-1] = 1'b0;
                end

                ibuf_pkg::OP_HALF: begin
                    for (int l = 0; l < ibuf_pkg::HALF; l++) begin
                        data_d[b][l]  = data_q[b][l+ibuf_pkg::HALF];
                        valid_d[b][l] = valid_q[b][l+ibuf_pkg::HALF];
                        data_d[b][l+ibuf_pkg::HALF]  = init;
                        valid_d[b][l+ibuf_pkg::HALF] = 1'b0;
                    end
                end

                ibuf_pkg::OP_CLEAR: begin
                    for (int l = 0; l < ibuf_pkg::LANES; l++) begin
                        data_d[b][l] = init;
                    end
                    valid_d[b] = '0;
                end

                ibuf_pkg::OP_TAKE_UPPER: begin
                    // source is the old content of the last bank
                    for (int l = 0; l < ibuf_pkg::HALF; l++) begin
                        data_d[b][l]  = init;
                        valid_d[b][l] = 1'b0;
                        data_d[b][l+ibuf_pkg::HALF] =
                            data_q[ibuf_pkg::BANKS-1][l+ibuf_pkg::HALF];
                        valid_d[b][l+ibuf_pkg::HALF] =
                            valid_q[ibuf_pkg::BANKS-1][l+ibuf_pkg::HALF];
                    end
                end

                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
                data_q[b]  <= '0;
                valid_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < ibuf_pkg::BANKS; b++) begin
                data_q[b]  <= data_d[b];
                valid_q[b] <= valid_d[b];
            end
        end
    end

    assign bank_data  = data_q;
    assign bank_valid = valid_q;

endmodule

//--- rtl/ibuf_window_sel.sv
module ibuf_window_sel (
    input  logic [3:0]                 cfg_layer_typ,
    input  logic                       conv_se_load,
    input  logic                       conv_fi_load,
    input  logic                       do_revert,
    input  ibuf_pkg::window_t          bank_data  [ibuf_pkg::BANKS],
    input  logic [ibuf_pkg::LANES-1:0] bank_valid [ibuf_pkg::BANKS],
    output ibuf_pkg::lane_t            do_0,
    output ibuf_pkg::lane_t            do_1,
    output ibuf_pkg::lane_t            do_2,
    output logic [2:0]                 valid,
    output logic [2:0]                 nxt_valid
);

    logic is_conv;
    logic is_pool;

    assign is_conv = (cfg_layer_typ == ibuf_pkg::LAYER_CONV);
    assign is_pool = (cfg_layer_typ == ibuf_pkg::LAYER_POOL);

    always_comb begin
        do_0      = '0;
        do_1      = '0;
        do_2      = '0;
        valid     = '0;
        nxt_valid = '0;

        if (is_conv && (conv_se_load || conv_fi_load)) begin
            // three front lanes of bank 2, no lookahead
            if (do_revert) begin
                do_0  = bank_data[2][2];
                do_1  = bank_data[2][1];
                do_2  = bank_data[2][0];
                valid = {bank_valid[2][0], bank_valid[2][1], bank_valid[2][2]};
            end else begin
                do_0  = bank_data[2][0];
                do_1  = bank_data[2][1];
                do_2  = bank_data[2][2];
                valid = bank_valid[2][2:0];
            end
        end else if (is_conv || is_pool) begin
            // front byte of each bank, bank 0 in bit 0
            do_0      = bank_data[0][0];
            do_1      = bank_data[1][0];
            do_2      = bank_data[2][0];
            valid     = {bank_valid[2][0], bank_valid[1][0], bank_valid[0][0]};
            nxt_valid = {bank_valid[2][1], bank_valid[1][1], bank_valid[0][1]};
        end
    end

endmodule

//--- rtl/ibuf_top.sv
module ibuf_top (
    input  logic [3:0]                  cfg_layer_typ,
    input  logic [ibuf_pkg::WORD_W-1:0] di,
    input  ibuf_pkg::lane_t             init,
    output ibuf_pkg::lane_t             do_0,
    output ibuf_pkg::lane_t             do_1,
    output ibuf_pkg::lane_t             do_2,
    output logic [2:0]                  valid,
    output logic [2:0]                  nxt_valid,
    input  logic                        di_revert,
    input  logic                        do_revert,
    input  logic                        ld_wrn,
    input  logic [1:0]                  bank_sel,
    input  logic [2:0]                  conv_wstrb,
    input  logic                        conv_fi_load,
    input  logic                        conv_se_load,
    input  logic                        enb,
    input  logic                        clk,
    input  logic                        resetn
);

    ibuf_pkg::window_t          lane_data;
    logic [ibuf_pkg::LANES-1:0] lane_wr;
    logic [ibuf_pkg::LANES-1:0] lane_valid;
    ibuf_pkg::bank_op_t         bank_op    [ibuf_pkg::BANKS];
    ibuf_pkg::window_t          bank_data  [ibuf_pkg::BANKS];
    logic [ibuf_pkg::LANES-1:0] bank_valid [ibuf_pkg::BANKS];

    ibuf_word_align i_word_align (
        .di         (di),
        .di_revert  (di_revert),
        .conv_wstrb (conv_wstrb),
        .init       (init),
        .lane_data  (lane_data),
        .lane_wr    (lane_wr),
        .lane_valid (lane_valid)
    );

    ibuf_move_ctrl i_move_ctrl (
        .enb           (enb),
        .ld_wrn        (ld_wrn),
        .cfg_layer_typ (cfg_layer_typ),
        .bank_sel      (bank_sel),
        .conv_se_load  (conv_se_load),
        .conv_fi_load  (conv_fi_load),
        .bank_op       (bank_op)
    );

    ibuf_bank_array i_bank_array (
        .clk        (clk),
        .resetn     (resetn),
        .bank_op    (bank_op),
        .lane_data  (lane_data),
        .lane_wr    (lane_wr),
        .lane_valid (lane_valid),
        .init       (init),
        .bank_data  (bank_data),
        .bank_valid (bank_valid)
    );

    ibuf_window_sel i_window_sel (
        .cfg_layer_typ (cfg_layer_typ),
        .conv_se_load  (conv_se_load),
        .conv_fi_load  (conv_fi_load),
        .do_revert     (do_revert),
        .bank_data     (bank_data),
        .bank_valid    (bank_valid),
        .do_0          (do_0),
        .do_1          (do_1),
        .do_2          (do_2),
        .valid         (valid),
        .nxt_valid     (nxt_valid)
    );

endmodule

//--- bench/tb_ibuf.sv
module tb_ibuf;

    timeunit 1ns;
    timeprecision 100ps;

    logic [3:0]  cfg_layer_typ;
    logic [31:0] di;
    logic [7:0]  init;
    logic [7:0]  do_0;
    logic [7:0]  do_1;
    logic [7:0]  do_2;
    logic [2:0]  valid;
    logic [2:0]  nxt_valid;
    logic        di_revert;
    logic        do_revert;
    logic        ld_wrn;
    logic [1:0]  bank_sel;
    logic [2:0]  conv_wstrb;
    logic        conv_fi_load;
    logic        conv_se_load;
    logic        enb;
    logic        clk;
    logic        resetn;

    // model copy of the three banks
    logic [7:0] m_data  [3][6];
    logic       m_valid [3][6];

    logic checking;
    int   errors;
    int   checks;
    int   cycles;

    ibuf_top i_ibuf_top (
        .cfg_layer_typ (cfg_layer_typ),
        .di            (di),
        .init          (init),
        .do_0          (do_0),
        .do_1          (do_1),
        .do_2          (do_2),
        .valid         (valid),
        .nxt_valid     (nxt_valid),
        .di_revert     (di_revert),
        .do_revert     (do_revert),
        .ld_wrn        (ld_wrn),
        .bank_sel      (bank_sel),
        .conv_wstrb    (conv_wstrb),
        .conv_fi_load  (conv_fi_load),
        .conv_se_load  (conv_se_load),
        .enb           (enb),
        .clk           (clk),
        .resetn        (resetn)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // lane values, write mask and valid mask for one input word
    function automatic void align_ref(input logic [31:0] word, input logic rev,
                                      input logic [2:0] strb, input logic [7:0] fill,
                                      output logic [47:0] ldat, output logic [5:0] lwr,
                                      output logic [5:0] lval);
        logic [31:0] w;
        int          k;
        w    = rev ? {word[7:0], word[15:8], word[23:16], word[31:24]} : word;
        ldat = {6{fill}};
        lwr  = '0;
        lval = '0;
        if (strb <= ibuf_pkg::STRB_SHIFT3) begin
            k   = int'(strb);
            lwr = '1;
            for (int i = 0; i <= 3 - k; i++) begin
                ldat[8*i +: 8] = w[8*(i+k) +: 8];
                lval[i]        = 1'b1;
            end
        end else if (strb == ibuf_pkg::STRB_AT2 || strb == ibuf_pkg::STRB_AT1) begin
            k = (strb == ibuf_pkg::STRB_AT2) ? 2 : 1;
            for (int i = 0; i < 4; i++) begin
                ldat[8*(i+k) +: 8] = w[8*i +: 8];
                lwr[i+k]           = 1'b1;
                lval[i+k]          = 1'b1;
            end
        end
    endfunction

    function automatic void reset_model();
        for (int b = 0; b < 3; b++) begin
            for (int l = 0; l < 6; l++) begin
                m_data[b][l]  = '0;
                m_valid[b][l] = 1'b0;
            end
        end
    endfunction

    // one clock edge of the reference buffer
    function automatic void step_model(input logic en, input logic ld, input logic [3:0] layer,
                                       input logic [1:0] sel, input logic se, input logic fi,
                                       input logic [31:0] word, input logic rev,
                                       input logic [2:0] strb, input logic [7:0] fill);
        logic [7:0]         old_d [3][6];
        logic               old_v [3][6];
        ibuf_pkg::bank_op_t op    [3];
        logic [47:0]        ldat;
        logic [5:0]         lwr;
        logic [5:0]         lval;
        old_d = m_data;
        old_v = m_valid;
        align_ref(word, rev, strb, fill, ldat, lwr, lval);
        op = '{ibuf_pkg::OP_HOLD, ibuf_pkg::OP_HOLD, ibuf_pkg::OP_HOLD};
        if (en && ld && (layer == 4'd0 || layer == 4'd2) && sel != 2'd0) begin
            op[int'(sel) - 1] = ibuf_pkg::OP_LOAD;
        end else if (en && !ld && layer == 4'd2) begin
            op = '{ibuf_pkg::OP_STEP, ibuf_pkg::OP_STEP, ibuf_pkg::OP_STEP};
        end else if (en && !ld && layer == 4'd0) begin
            case ({se, fi})
                2'b11: op = '{ibuf_pkg::OP_CLEAR, ibuf_pkg::OP_HALF, ibuf_pkg::OP_HALF};
                2'b10: op = '{ibuf_pkg::OP_CLEAR, ibuf_pkg::OP_TAKE_UPPER, ibuf_pkg::OP_CLEAR};
                2'b01: op = '{ibuf_pkg::OP_CLEAR, ibuf_pkg::OP_CLEAR, ibuf_pkg::OP_HALF};
                default: op = '{ibuf_pkg::OP_STEP, ibuf_pkg::OP_STEP, ibuf_pkg::OP_STEP};
            endcase
        end
        for (int b = 0; b < 3; b++) begin
            for (int l = 0; l < 6; l++) begin
                // moves and clears leave init behind unless a lane is refilled below
                if (op[b] != ibuf_pkg::OP_HOLD && op[b] != ibuf_pkg::OP_LOAD) begin
                    m_data[b][l]  = fill;
                    m_valid[b][l] = 1'b0;
                end
                case (op[b])
                    ibuf_pkg::OP_LOAD: begin
                        if (lwr[l]) begin
                            m_data[b][l]  = ldat[8*l +: 8];
                            m_valid[b][l] = lval[l];
                        end
                    end
                    ibuf_pkg::OP_STEP: begin
                        if (l < 5) begin
                            m_data[b][l]  = old_d[b][l+1];
                            m_valid[b][l] = old_v[b][l+1];
                        end
                    end
                    ibuf_pkg::OP_HALF: begin
                        if (l < 3) begin
                            m_data[b][l]  = old_d[b][l+3];
                            m_valid[b][l] = old_v[b][l+3];
                        end
                    end
                    ibuf_pkg::OP_TAKE_UPPER: begin
                        if (l >= 3) begin
                            m_data[b][l]  = old_d[2][l];
                            m_valid[b][l] = old_v[2][l];
                        end
                    end
                    default: ;
                endcase
            end
        end
    endfunction

    // expected {do_0, do_1, do_2, valid, nxt_valid}
    function automatic logic [29:0] expected_window(input logic [3:0] layer, input logic se,
                                                    input logic fi, input logic rev);
        logic [7:0] o [3];
        logic [2:0] v;
        logic [2:0] nv;
        int         idx;
        o  = '{8'h00, 8'h00, 8'h00};
        v  = '0;
        nv = '0;
        for (int j = 0; j < 3; j++) begin
            if (layer == 4'd0 && (se || fi)) begin
                idx  = rev ? 2 - j : j;
                o[j] = m_data[2][idx];
                v[j] = m_valid[2][idx];
            end else if (layer == 4'd0 || layer == 4'd2) begin
                o[j]  = m_data[j][0];
                v[j]  = m_valid[j][0];
                nv[j] = m_valid[j][1];
            end
        end
        return {o[0], o[1], o[2], v, nv};
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            reset_model();
        end else begin
            step_model(enb, ld_wrn, cfg_layer_typ, bank_sel, conv_se_load, conv_fi_load,
                       di, di_revert, conv_wstrb, init);
        end
    end

    // every output against the model, between rising edges
    always @(negedge clk) begin
        logic [29:0] want;
        want = expected_window(cfg_layer_typ, conv_se_load, conv_fi_load, do_revert);
        if (checking) begin
            checks++;
            if (do_0 !== want[29:22]) begin
                errors++;
                $display("Fail at %0t: do_0 is %h, expected %h", $time, do_0, want[29:22]);
            end
            if (do_1 !== want[21:14]) begin
                errors++;
                $display("Fail at %0t: do_1 is %h, expected %h", $time, do_1, want[21:14]);
            end
            if (do_2 !== want[13:6]) begin
                errors++;
                $display("Fail at %0t: do_2 is %h, expected %h", $time, do_2, want[13:6]);
            end
            if (valid !== want[5:3]) begin
                errors++;
                $display("Fail at %0t: valid is %b, expected %b", $time, valid, want[5:3]);
            end
            if (nxt_valid !== want[2:0]) begin
                errors++;
                $display("Fail at %0t: nxt_valid is %b, expected %b", $time, nxt_valid,
                         want[2:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 3000) begin
            $display("timeout: the tests did not finish within 3000 cycles");
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic drive_cycle(input logic en, input logic ld, input logic [3:0] layer,
                               input logic [1:0] sel, input logic se, input logic fi,
                               input logic orev, input logic [2:0] strb,
                               input logic [31:0] word, input logic rev);
        @(posedge clk);
        enb           <= en;
        ld_wrn        <= ld;
        cfg_layer_typ <= layer;
        bank_sel      <= sel;
        conv_se_load  <= se;
        conv_fi_load  <= fi;
        do_revert     <= orev;
        conv_wstrb    <= strb;
        di            <= word;
        di_revert     <= rev;
        init          <= 8'($urandom());
    endtask

    // lanes 0-1 of each bank from a shifted word and lanes 2-5 from a word placed at lane 2
    task automatic fill_banks();
        for (int b = 1; b <= 3; b++) begin
            drive_cycle(1, 1, 4'd0, 2'(b), 0, 0, 0, ibuf_pkg::STRB_SHIFT0, $urandom(), 0);
            drive_cycle(1, 1, 4'd0, 2'(b), 0, 0, 0, ibuf_pkg::STRB_AT2, $urandom(), 1);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  layer;
        void'($urandom(32'h0546e9c3));
        cfg_layer_typ = 4'd0;
        di            = '0;
        init          = '0;
        di_revert     = 1'b0;
        do_revert     = 1'b0;
        ld_wrn        = 1'b0;
        bank_sel      = 2'd0;
        conv_wstrb    = 3'd0;
        conv_fi_load  = 1'b0;
        conv_se_load  = 1'b0;
        enb           = 1'b0;
        resetn        = 1'b0;
        checking      = 1'b0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        repeat (3) @(posedge clk);
        resetn   <= 1'b1;
        checking <= 1'b1;

        drive_cycle(0, 0, 4'd2, 0, 0, 0, 0, 0, 0, 0);
        @(negedge clk);
        if ({do_0, do_1, do_2, valid, nxt_valid} !== '0) begin
            errors++;
            $display("Fail at %0t: outputs not zero after reset", $time);
        end

        // every strobe code into every bank, then read out lane by lane
        for (int code = 0; code < 8; code++) begin
            for (int rv = 0; rv < 2; rv++) begin
                for (int b = 1; b <= 3; b++) begin
                    layer = (b == 2) ? 4'd2 : 4'd0;
                    drive_cycle(1, 1, layer, 2'(b), 0, 0, 0, 3'(code), $urandom(), rv[0]);
                end
                drive_cycle(1, 1, 4'd2, 2'd0, 0, 0, 0, 3'(code), $urandom(), 0);
                repeat (6) drive_cycle(1, 0, 4'd2, 0, 0, 0, 0, 0, 0, 0);
            end
        end

        // flagged window shown both ways before each conv move
        for (int c = 0; c < 4; c++) begin
            fill_banks();
            drive_cycle(0, 0, 4'd0, 0, 1, 0, 0, 0, 0, 0);
            drive_cycle(0, 0, 4'd0, 0, 0, 1, 1, 0, 0, 0);
            drive_cycle(1, 0, 4'd0, 0, c[1], c[0], c[1] ^ c[0], 0, 0, 0);
            repeat (6) drive_cycle(1, 0, 4'd0, 0, 0, 0, 0, 0, 0, 0);
        end

        // frozen state with enb low, then layer codes outside conv and pool
        fill_banks();
        repeat (4) begin
            r = $urandom();
            layer = r[1] ? 4'd2 : 4'd0;
            drive_cycle(0, r[0], layer, 2'(r[3:2]), r[4], r[5], r[6], 3'(r[9:7]),
                        $urandom(), r[10]);
        end
        repeat (4) begin
            r = $urandom();
            layer = {r[3:1], 1'b1};
            drive_cycle(1, r[0], layer, 2'(r[5:4]), r[6], r[7], r[8], 3'(r[11:9]),
                        $urandom(), r[12]);
        end
        repeat (6) drive_cycle(1, 0, 4'd2, 0, 0, 0, 0, 0, 0, 0);

        for (int n = 0; n < 2000; n++) begin
            r = $urandom();
            if (r[20:18] == 3'd7) begin
                layer = 4'($urandom());
            end else begin
                layer = r[0] ? 4'd2 : 4'd0;
            end
            drive_cycle(r[3:1] != 3'd0, r[4], layer, 2'(r[6:5]), r[7] & r[8], r[9] & r[10],
                        r[11], 3'(r[14:12]), $urandom(), r[15]);
        end

        drive_cycle(0, 0, 4'd0, 0, 0, 0, 0, 0, 0, 0);
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/ibuf_pkg.sv
rtl/ibuf_word_align.sv
rtl/ibuf_move_ctrl.sv
rtl/ibuf_bank_array.sv
rtl/ibuf_window_sel.sv
rtl/ibuf_top.sv
bench/tb_ibuf.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_ibuf
RTL_TOP    ?= ibuf_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := rtl/ibuf_pkg.sv rtl/ibuf_word_align.sv rtl/ibuf_move_ctrl.sv \
            rtl/ibuf_bank_array.sv rtl/ibuf_window_sel.sv rtl/ibuf_top.sv
TB_SRCS  := bench/tb_ibuf.sv

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx 'Done: no errors' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
